//--- hw/stmm_fetch_settings.svh
`ifndef STMM_FETCH_SETTINGS_SVH
`define STMM_FETCH_SETTINGS_SVH

//////////////////////////////////////////////////
// weight memory geometry
//////////////////////////////////////////////////

// sdram data bus width, one block
`define STMM_SDRAM_W 128

// blocks per bram line, 2 to 11 supported
`define STMM_BLK_NUM 4

// lines per weight matrix
`define STMM_BRAM_L 8

// one packed bram line
`define STMM_LINE_W (`STMM_SDRAM_W * `STMM_BLK_NUM)

// sdram byte address
`define STMM_ADDR_W 32

`endif

//--- hw/stmm_pkg.sv
`include "stmm_fetch_settings.svh"

package stmm_pkg;

    // quantization record, last word of a weight fetch
    typedef struct packed {
        logic [15:0]        rsvd3;
        logic [15:0]        scale_fp16;
        logic [23:0]        rsvd2;
        logic signed [7:0]  zero;
        logic [23:0]        rsvd1;
        logic signed [7:0]  z_w;
        logic [23:0]        rsvd0;
        logic signed [7:0]  z_x;
    } quant_rec_t;

    // one sdram word, either matrix data or the quant record
    typedef union packed {
        logic [`STMM_SDRAM_W-1:0] blk;
        quant_rec_t               quant;
    } sdram_word_u;

    typedef enum logic [1:0] {
        IDLE,
        RECV_MAT,
        RECV_QUANT
    } fetch_state_t;

endpackage

//--- hw/sdram_read_if.sv
`include "stmm_fetch_settings.svh"

interface sdram_read_if;

    // request side
    logic                     read_start;
    logic [`STMM_ADDR_W-1:0]  read_addr;
    logic [10:0]              read_cnt;

    // return side
    logic                     read_valid;
    stmm_pkg::sdram_word_u    read_data;
    logic                     read_done;

    modport fetch (
        output read_start,
        output read_addr,
        output read_cnt,
        input  read_valid,
        input  read_data,
        input  read_done
    );

    modport reader (
        input  read_start,
        input  read_addr,
        input  read_cnt,
        output read_valid,
        output read_data,
        output read_done
    );

endinterface

//--- hw/sdram_burst_reader.sv
`include "stmm_fetch_settings.svh"

module sdram_burst_reader (
    input  logic                      clk,
    input  logic                      rst_n,

    sdram_read_if.reader              rd,

    output logic [`STMM_ADDR_W-1:0]   o_avm_address,
    output logic                      o_avm_read,
    output logic [10:0]               o_avm_burstcount,
    input  logic                      i_avm_waitrequest,
    input  logic [`STMM_SDRAM_W-1:0]  i_avm_readdata,
    input  logic                      i_avm_readdatavalid
);

    logic        busy;
    logic [10:0] words_left;
    logic        last_word;

    //////////////////////////////////////////////////
    // avalon command
    //////////////////////////////////////////////////

    // address and length latched with the request
    always_ff @(posedge clk) begin
        if (rd.read_start) begin
            o_avm_address    <= rd.read_addr;
            o_avm_burstcount <= rd.read_cnt;
        end
    end

    // read held until the slave drops waitrequest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_avm_read <= 1'b0;
        end else if (rd.read_start) begin
            o_avm_read <= 1'b1;
        end else if (!i_avm_waitrequest) begin
            o_avm_read <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // returning words
    //////////////////////////////////////////////////

    // stray readdatavalid outside a burst is ignored
    assign rd.read_valid    = busy && i_avm_readdatavalid;
    assign rd.read_data.blk = i_avm_readdata;
    assign last_word        = rd.read_valid && (words_left == 11'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            words_left   <= '0;
            rd.read_done <= 1'b0;
        end else begin
            // done trails the last word by one cycle
            rd.read_done <= last_word;
            if (rd.read_start) begin
                busy       <= 1'b1;
                words_left <= rd.read_cnt;
            end else if (rd.read_valid) begin
                words_left <= words_left - 11'd1;
                if (last_word) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hw/stmm_fetch.sv
`include "stmm_fetch_settings.svh"

module stmm_fetch (
    input  logic                              clk,
    input  logic                              rst_n,

    sdram_read_if.fetch                       rd,

    output logic                              o_bram_we,
    output logic [$clog2(`STMM_BRAM_L)-1:0]   o_bram_addr,
    output logic [`STMM_LINE_W-1:0]           o_bram_data,

    input  logic                              i_start,
    input  logic [`STMM_ADDR_W-1:0]           i_fetch_addr,
    output logic                              o_done,

    output logic                              o_quant_valid,
    output logic [15:0]                       o_scale_fp16,
    output logic signed [7:0]                 o_z_x,
    output logic signed [7:0]                 o_z_w,
    output logic signed [7:0]                 o_zero
);

    localparam int LINE_AW = $clog2(`STMM_BRAM_L);
    localparam int BLK_CW  = $clog2(`STMM_BLK_NUM);
    localparam logic [`STMM_ADDR_W-1:0] LINE_STRIDE = 16 * `STMM_BLK_NUM;
    localparam logic [10:0] BURST_LEN = 11'(`STMM_BLK_NUM);

    stmm_pkg::fetch_state_t state;
    stmm_pkg::fetch_state_t nxt_state;

    logic [`STMM_ADDR_W-1:0] line_addr;
    logic [LINE_AW-1:0]      line_cnt;
    logic [BLK_CW-1:0]       blk_cnt;
    logic                    take_start;
    logic                    line_end;
    logic                    last_line;
    logic                    blk_store;

    // block 0 sits in the low bits of the line
    logic [`STMM_BLK_NUM-1:0][`STMM_SDRAM_W-1:0] line_buf;
    stmm_pkg::quant_rec_t                        quant_q;

    assign take_start = (state == stmm_pkg::IDLE) && i_start;
    assign line_end   = (state == stmm_pkg::RECV_MAT) && rd.read_done;
    assign blk_store  = (state == stmm_pkg::RECV_MAT) && rd.read_valid;
    assign last_line  = (line_cnt == LINE_AW'(`STMM_BRAM_L - 1));

    //////////////////////////////////////////////////
    // counters and line buffer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= stmm_pkg::IDLE;
            line_addr <= '0;
            line_cnt  <= '0;
            blk_cnt   <= '0;
        end else begin
            state <= nxt_state;
            if (take_start) begin
                line_addr <= i_fetch_addr;
                line_cnt  <= '0;
                blk_cnt   <= '0;
            end else if (line_end) begin
                line_addr <= line_addr + LINE_STRIDE;
                line_cnt  <= line_cnt + 1'b1;
                blk_cnt   <= '0;
            end else if (blk_store) begin
                blk_cnt <= blk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (blk_store) begin
            line_buf[blk_cnt] <= rd.read_data.blk;
        end
    end

    // quant word taken through the record view, held until the next fetch
    always_ff @(posedge clk) begin
        if ((state == stmm_pkg::RECV_QUANT) && rd.read_valid) begin
            quant_q <= rd.read_data.quant;
        end
    end

    //////////////////////////////////////////////////
    // fetch FSM
    //////////////////////////////////////////////////

    always_comb begin
        nxt_state     = state;
        rd.read_start = 1'b0;
        rd.read_cnt   = BURST_LEN;
        o_bram_we     = 1'b0;
        o_quant_valid = 1'b0;
        case (state)
            stmm_pkg::IDLE: begin
                if (i_start) begin
                    rd.read_start = 1'b1;
                    nxt_state     = stmm_pkg::RECV_MAT;
                end
            end
            stmm_pkg::RECV_MAT: begin
                // line complete, write it and chain the next burst
                if (rd.read_done) begin
                    o_bram_we     = 1'b1;
                    rd.read_start = 1'b1;
                    if (last_line) begin
                        rd.read_cnt = 11'd1;
                        nxt_state   = stmm_pkg::RECV_QUANT;
                    end
                end
            end
            default: begin
                if (rd.read_done) begin
                    o_quant_valid = 1'b1;
                    nxt_state     = stmm_pkg::IDLE;
                end
            end
        endcase
    end

    // next burst always follows the current line
    assign rd.read_addr = (state == stmm_pkg::IDLE) ? i_fetch_addr : line_addr + LINE_STRIDE;
    assign o_done       = (state == stmm_pkg::IDLE);

    assign o_bram_addr  = line_cnt;
    assign o_bram_data  = line_buf;

    assign o_scale_fp16 = quant_q.scale_fp16;
    assign o_z_x        = quant_q.z_x;
    assign o_z_w        = quant_q.z_w;
    assign o_zero       = quant_q.zero;

endmodule

//--- hw/weight_bram.sv
`include "stmm_fetch_settings.svh"

module weight_bram (
    input  logic                              clk,

    input  logic                              i_we,
    input  logic [$clog2(`STMM_BRAM_L)-1:0]   i_waddr,
    input  logic [`STMM_LINE_W-1:0]           i_wdata,

    input  logic [$clog2(`STMM_BRAM_L)-1:0]   i_raddr,
    output logic [`STMM_LINE_W-1:0]           o_rdata
);

    logic [`STMM_LINE_W-1:0] mem [0:`STMM_BRAM_L-1];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // same-address collision returns the new line
        if (i_we && (i_waddr == i_raddr)) begin
            o_rdata <= i_wdata;
        end else begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

//--- hw/stmm_fetch_top.sv
`include "stmm_fetch_settings.svh"

module stmm_fetch_top (
    input  logic                              clk,
    input  logic                              rst_n,

    // control
    input  logic                              i_start,
    input  logic [`STMM_ADDR_W-1:0]           i_fetch_addr,
    output logic                              o_done,

    // quant record
    output logic                              o_quant_valid,
    output logic [15:0]                       o_scale_fp16,
    output logic signed [7:0]                 o_z_x,
    output logic signed [7:0]                 o_z_w,
    output logic signed [7:0]                 o_zero,

    // avalon-mm read master
    output logic [`STMM_ADDR_W-1:0]           o_avm_address,
    output logic                              o_avm_read,
    output logic [10:0]                       o_avm_burstcount,
    input  logic                              i_avm_waitrequest,
    input  logic [`STMM_SDRAM_W-1:0]          i_avm_readdata,
    input  logic                              i_avm_readdatavalid,

    // weight read port for the compute array
    input  logic [$clog2(`STMM_BRAM_L)-1:0]   i_rd_addr,
    output logic [`STMM_LINE_W-1:0]           o_rd_data
);

    logic                             bram_we;
    logic [$clog2(`STMM_BRAM_L)-1:0]  bram_addr;
    logic [`STMM_LINE_W-1:0]          bram_data;

    sdram_read_if u_rd_if ();

    sdram_burst_reader u_reader (
        .clk                 (clk),
        .rst_n               (rst_n),
        .rd                  (u_rd_if.reader),
        .o_avm_address       (o_avm_address),
        .o_avm_read          (o_avm_read),
        .o_avm_burstcount    (o_avm_burstcount),
        .i_avm_waitrequest   (i_avm_waitrequest),
        .i_avm_readdata      (i_avm_readdata),
        .i_avm_readdatavalid (i_avm_readdatavalid)
    );

    stmm_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd            (u_rd_if.fetch),
        .o_bram_we     (bram_we),
        .o_bram_addr   (bram_addr),
        .o_bram_data   (bram_data),
        .i_start       (i_start),
        .i_fetch_addr  (i_fetch_addr),
        .o_done        (o_done),
        .o_quant_valid (o_quant_valid),
        .o_scale_fp16  (o_scale_fp16),
        .o_z_x         (o_z_x),
        .o_z_w         (o_z_w),
        .o_zero        (o_zero)
    );

    weight_bram u_bram (
        .clk     (clk),
        .i_we    (bram_we),
        .i_waddr (bram_addr),
        .i_wdata (bram_data),
        .i_raddr (i_rd_addr),
        .o_rdata (o_rd_data)
    );

endmodule

//--- tb/stmm_fetch_checker.sv
`include "stmm_fetch_settings.svh"

module stmm_fetch_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_start,
    input  logic [`STMM_ADDR_W-1:0]           i_fetch_addr,
    input  logic                              i_done,
    input  logic                              i_quant_valid,
    input  logic [15:0]                       i_scale_fp16,
    input  logic [7:0]                        i_z_x,
    input  logic [7:0]                        i_z_w,
    input  logic [7:0]                        i_zero,
    input  logic [`STMM_ADDR_W-1:0]           i_avm_address,
    input  logic                              i_avm_read,
    input  logic [10:0]                       i_avm_burstcount,
    input  logic                              i_avm_waitrequest,
    input  logic                              i_rd_check,
    input  logic [$clog2(`STMM_BRAM_L)-1:0]   i_rd_addr,
    input  logic [`STMM_LINE_W-1:0]           i_rd_data,
    output int                                o_errs,
    output int                                o_checks,
    output int                                o_fetches
);

    localparam int STRIDE = 16 * `STMM_BLK_NUM;
    localparam int N_CMD  = `STMM_BRAM_L + 1;

    logic [`STMM_ADDR_W-1:0]          base;
    logic [`STMM_SDRAM_W-1:0]         qw;
    logic [$clog2(`STMM_BRAM_L)-1:0]  chk_addr;
    int                               cmd_idx;
    int                               q_cnt;
    logic                             active;
    logic                             done_q;
    logic                             qv_q;
    logic                             took_q;
    logic                             q_hold;
    logic                             chk_q;

    function automatic logic [`STMM_SDRAM_W-1:0] mem_word(input logic [`STMM_ADDR_W-1:0] a);
        return tb_stmm_fetch.mem[a >> 4];
    endfunction

    // expected line k of the current fetch with block 0 lowest
    function automatic logic [`STMM_LINE_W-1:0] line_model(input int k);
        logic [`STMM_LINE_W-1:0] l;
        for (int b = 0; b < `STMM_BLK_NUM; b++) begin
            l[b*`STMM_SDRAM_W +: `STMM_SDRAM_W] = mem_word(base + k * STRIDE + b * 16);
        end
        return l;
    endfunction

    task automatic check_value(input string test, input logic [`STMM_LINE_W-1:0] exp,
                               input logic [`STMM_LINE_W-1:0] act);
        o_checks++;
        if (exp !== act) begin
            o_errs++;
            $display("FAILED %s (fetch %0d): expected %0h, actual %0h", test, o_fetches, exp, act);
        end
    endtask

    task automatic report_fault(input string what);
        o_errs++;
        $display("ERROR (fetch %0d): %s", o_fetches, what);
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_errs    = 0;
            o_checks  = 0;
            o_fetches = 0;
            base      = '0;
            cmd_idx   = 0;
            q_cnt     = 0;
            active    = 1'b0;
            done_q    = 1'b1;
            qv_q      = 1'b0;
            took_q    = 1'b0;
            q_hold    = 1'b0;
            chk_q     = 1'b0;
        end else begin
            //////////////////////////////////////////////////
            // done timing
            //////////////////////////////////////////////////
            if (took_q && i_done) begin
                report_fault("o_done still high the cycle after start was taken");
            end
            if (!took_q && done_q && !i_done) begin
                report_fault("o_done fell without an accepted start");
            end
            if (qv_q && !i_done) begin
                report_fault("o_done low the cycle after o_quant_valid");
            end
            if (!qv_q && !done_q && i_done) begin
                report_fault("o_done rose without a preceding o_quant_valid");
            end
            if (i_done && !done_q) begin
                check_value("command_count", N_CMD, cmd_idx);
                check_value("quant_pulses", 1, q_cnt);
                active = 1'b0;
            end

            // one avalon command per line and then the quant word
            if (i_avm_read && !i_avm_waitrequest) begin
                if (!active || cmd_idx >= N_CMD) begin
                    report_fault("Avalon command accepted with no request pending");
                end else begin
                    check_value("cmd_address", base + cmd_idx * STRIDE, i_avm_address);
                    check_value("cmd_burstcount",
                                (cmd_idx < `STMM_BRAM_L) ? `STMM_BLK_NUM : 1, i_avm_burstcount);
                    cmd_idx++;
                end
            end

            //////////////////////////////////////////////////
            // quant record and readback
            //////////////////////////////////////////////////
            if (i_quant_valid) begin
                if (!active) begin
                    report_fault("o_quant_valid pulsed while no fetch was running");
                end
                q_cnt++;
                qw     = mem_word(base + `STMM_BRAM_L * STRIDE);
                q_hold = 1'b1;
            end
            if (q_hold) begin
                check_value("quant_z_x", qw[7:0], i_z_x);
                check_value("quant_z_w", qw[39:32], i_z_w);
                check_value("quant_zero", qw[71:64], i_zero);
                check_value("quant_scale_fp16", qw[111:96], i_scale_fp16);
            end
            if (chk_q) begin
                check_value("bram_line", line_model(chk_addr), i_rd_data);
            end
            chk_q    = i_rd_check;
            chk_addr = i_rd_addr;

            if (i_start && i_done) begin
                base    = i_fetch_addr;
                cmd_idx = 0;
                q_cnt   = 0;
                q_hold  = 1'b0;
                active  = 1'b1;
                o_fetches++;
            end
            took_q = i_start && i_done;
            done_q = i_done;
            qv_q   = i_quant_valid;
        end
    end

endmodule

//--- tb/tb_stmm_fetch.sv
`include "stmm_fetch_settings.svh"

module tb_stmm_fetch;

    localparam int MEM_WORDS = 1024;
    localparam int STRIDE    = 16 * `STMM_BLK_NUM;
    localparam int RD_AW     = $clog2(`STMM_BRAM_L);
    localparam int N_FETCH   = 6;
    // stalls are capped at three cycles, so a burst stays far below 40 cycles
    localparam int WATCHDOG_CYC = 8 + N_FETCH * ((`STMM_BRAM_L + 1) * 40 + `STMM_BRAM_L + 6);

    logic                        clk;
    logic                        rst_n;
    logic                        start;
    logic [`STMM_ADDR_W-1:0]     fetch_addr;
    logic                        done;
    logic                        quant_valid;
    logic [15:0]                 scale_fp16;
    logic signed [7:0]           z_x;
    logic signed [7:0]           z_w;
    logic signed [7:0]           zero;
    logic [`STMM_ADDR_W-1:0]     avm_address;
    logic                        avm_read;
    logic [10:0]                 avm_burstcount;
    logic                        avm_waitrequest;
    logic [`STMM_SDRAM_W-1:0]    avm_readdata;
    logic                        avm_readdatavalid;
    logic                        rd_check;
    logic [RD_AW-1:0]            rd_addr;
    logic [`STMM_LINE_W-1:0]     rd_data;

    // sdram contents, one 128-bit word per 16 bytes
    logic [`STMM_SDRAM_W-1:0]    mem [0:MEM_WORDS-1];
    integer                      seed = 32'hf3a6;
    int                          errs;
    int                          checks;
    int                          fetches;
    int unsigned                 burst_word [$];
    int unsigned                 burst_len [$];
    int unsigned                 cur_word;
    int unsigned                 cur_left;
    int unsigned                 stall_run;
    int unsigned                 gap_run;

    stmm_fetch_top i_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_start             (start),
        .i_fetch_addr        (fetch_addr),
        .o_done              (done),
        .o_quant_valid       (quant_valid),
        .o_scale_fp16        (scale_fp16),
        .o_z_x               (z_x),
        .o_z_w               (z_w),
        .o_zero              (zero),
        .o_avm_address       (avm_address),
        .o_avm_read          (avm_read),
        .o_avm_burstcount    (avm_burstcount),
        .i_avm_waitrequest   (avm_waitrequest),
        .i_avm_readdata      (avm_readdata),
        .i_avm_readdatavalid (avm_readdatavalid),
        .i_rd_addr           (rd_addr),
        .o_rd_data           (rd_data)
    );

    stmm_fetch_checker u_checker (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_start             (start),
        .i_fetch_addr        (fetch_addr),
        .i_done              (done),
        .i_quant_valid       (quant_valid),
        .i_scale_fp16        (scale_fp16),
        .i_z_x               (z_x),
        .i_z_w               (z_w),
        .i_zero              (zero),
        .i_avm_address       (avm_address),
        .i_avm_read          (avm_read),
        .i_avm_burstcount    (avm_burstcount),
        .i_avm_waitrequest   (avm_waitrequest),
        .i_rd_check          (rd_check),
        .i_rd_addr           (rd_addr),
        .i_rd_data           (rd_data),
        .o_errs              (errs),
        .o_checks            (checks),
        .o_fetches           (fetches)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, fetch did not complete", WATCHDOG_CYC);
        $display("RESULT: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // avalon memory model
    //////////////////////////////////////////////////

    initial begin
        avm_waitrequest   = 1'b1;
        avm_readdatavalid = 1'b0;
        avm_readdata      = '0;
        cur_word          = 0;
        cur_left          = 0;
        stall_run         = 0;
        gap_run           = 0;
        forever begin
            @(posedge clk);
            if (rst_n && avm_read && !avm_waitrequest) begin
                burst_word.push_back(avm_address >> 4);
                burst_len.push_back(avm_burstcount);
            end
            #1;
            avm_waitrequest = (stall_run < 3) && ($random(seed) % 3 == 0);
            stall_run = avm_waitrequest ? stall_run + 1 : 0;
            if (cur_left == 0 && burst_word.size() > 0) begin
                cur_word = burst_word.pop_front();
                cur_left = burst_len.pop_front();
            end
            // in-order return with short random gaps
            avm_readdatavalid = (cur_left != 0) && !((gap_run < 3) && ($random(seed) % 3 == 0));
            gap_run = ((cur_left != 0) && !avm_readdatavalid) ? gap_run + 1 : 0;
            if (avm_readdatavalid) begin
                avm_readdata = mem[cur_word];
                cur_word++;
                cur_left--;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic run_fetch();
        int stray;
        int cyc;
        fetch_addr = ($unsigned($random(seed)) %
                      (MEM_WORDS / `STMM_BLK_NUM - `STMM_BRAM_L - 1)) * STRIDE;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        stray = 1 + $unsigned($random(seed)) % 4;
        cyc   = 0;
        // one start pulse while busy, which the fetch must ignore
        while (!done) begin
            start = (cyc == stray);
            if (cyc == stray) begin
                fetch_addr = $random(seed);
            end
            cyc++;
            @(posedge clk);
            #1;
        end
        start = 1'b0;
    endtask

    task automatic read_back();
        for (int k = 0; k < `STMM_BRAM_L; k++) begin
            rd_check = 1'b1;
            rd_addr  = RD_AW'(k);
            @(posedge clk);
            #1;
        end
        rd_check = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        fetch_addr = '0;
        rd_check   = 1'b0;
        rd_addr    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int f = 0; f < N_FETCH; f++) begin
            run_fetch();
            read_back();
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, fetches %0d of %0d", checks, errs, fetches, N_FETCH);
        if (errs == 0 && fetches == N_FETCH) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/stmm_pkg.sv
hw/sdram_read_if.sv
hw/sdram_burst_reader.sv
hw/stmm_fetch.sv
hw/weight_bram.sv
hw/stmm_fetch_top.sv
tb/stmm_fetch_checker.sv
tb/tb_stmm_fetch.sv

//--- Bender.yml
package:
  name: stmm_fetch

sources:
  - include_dirs:
      - hw
    files:
      - hw/stmm_pkg.sv
      - hw/sdram_read_if.sv
      - hw/sdram_burst_reader.sv
      - hw/stmm_fetch.sv
      - hw/weight_bram.sv
      - hw/stmm_fetch_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/stmm_fetch_checker.sv
      - tb/tb_stmm_fetch.sv
